// ==== design/div_datapath.sv ====
`timescale 1ns/1ps

module div_datapath #(
    parameter int WIDTH = md_pkg::DATA_W
) (
    input  logic               aclk,
    input  logic               aresetn,
    input  logic               load,
    input  logic               step,
    input  logic               is_signed,
    input  logic [WIDTH-1:0]   dividend,
    input  logic [WIDTH-1:0]   divisor,
    output md_pkg::hilo_t      result
);

    logic [WIDTH-1:0] rem_q;    // partial remainder
    logic [WIDTH-1:0] quo_q;    // dividend bits shift out, quotient bits shift in
    logic [WIDTH-1:0] dsr_q;
    logic             neg_q;
    logic             neg_r;

    logic [WIDTH-1:0] dvd_mag;
    logic [WIDTH-1:0] dsr_mag;
    logic [WIDTH-1:0] rem_src;
    logic [WIDTH-1:0] quo_src;
    logic [WIDTH-1:0] dsr_src;
    logic [WIDTH:0]   shifted;
    logic [WIDTH:0]   diff;
    logic             q_bit;

    assign dvd_mag = (is_signed && dividend[WIDTH-1]) ? -dividend : dividend;
    assign dsr_mag = (is_signed && divisor[WIDTH-1])  ? -divisor  : divisor;

    // load also takes the first step straight from the operands
    assign rem_src = load ? '0      : rem_q;
    assign quo_src = load ? dvd_mag : quo_q;
    assign dsr_src = load ? dsr_mag : dsr_q;

    assign shifted = {rem_src, quo_src[WIDTH-1]};
    assign diff    = shifted - {1'b0, dsr_src};
    assign q_bit   = !diff[WIDTH];    // no borrow, keep the difference

    always_ff @(posedge aclk) begin
        if (load || step) begin
            rem_q <= q_bit ? diff[WIDTH-1:0] : shifted[WIDTH-1:0];
            quo_q <= {quo_src[WIDTH-2:0], q_bit};
        end
        if (load) begin
            dsr_q <= dsr_mag;
        end
    end

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            neg_q <= 1'b0;
            neg_r <= 1'b0;
        end else if (load) begin
            neg_q <= is_signed && (dividend[WIDTH-1] ^ divisor[WIDTH-1]);
            neg_r <= is_signed && dividend[WIDTH-1];
        end
    end

    // quotient truncates toward zero, remainder follows the dividend sign
    always_comb begin
        result.hi = neg_r ? -rem_q : rem_q;
        result.lo = neg_q ? -quo_q : quo_q;
    end

endmodule

// ==== design/div_step_counter.sv ====
`timescale 1ns/1ps

module div_step_counter #(
    parameter int WIDTH = md_pkg::DATA_W
) (
    input  logic   aclk,
    input  logic   aresetn,
    input  logic   start,
    input  logic   enable,
    output logic   last_step
);

    localparam int CNT_W = $clog2(WIDTH);

    logic [CNT_W-1:0] cnt;

    // the load edge does the first step, so WIDTH-1 remain
    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            cnt <= '0;
        end else if (start) begin
            cnt <= CNT_W'(WIDTH - 1);
        end else if (enable) begin
            cnt <= cnt - 1'b1;
        end
    end

    assign last_step = cnt == CNT_W'(1);

    a_no_underflow: assert property (@(posedge aclk) disable iff (!aresetn)
        enable && !start |-> cnt != '0);

endmodule

// ==== design/hilo_file.sv ====
`timescale 1ns/1ps

module hilo_file #(
    parameter int WIDTH = md_pkg::DATA_W
) (
    input  logic               aclk,
    input  logic               aresetn,
    input  md_pkg::md_req_t    req,
    input  logic               hi_wen,
    input  logic               lo_wen,
    input  logic [1:0]         wr_src,
    input  md_pkg::hilo_t      div_result,
    output logic [WIDTH-1:0]   rdata
);

    md_pkg::hilo_t      hilo_q;
    md_pkg::hilo_t      wdata;
    logic               sign_ext;
    logic [2*WIDTH-1:0] rs_ext;
    logic [2*WIDTH-1:0] rt_ext;
    logic [2*WIDTH-1:0] product;

    // one multiplier for both, the low 2W bits are right either way
    assign sign_ext = req.op == md_pkg::OP_MULT;
    assign rs_ext   = {{WIDTH{sign_ext && req.rs_val[WIDTH-1]}}, req.rs_val};
    assign rt_ext   = {{WIDTH{sign_ext && req.rt_val[WIDTH-1]}}, req.rt_val};
    assign product  = rs_ext * rt_ext;

    always_comb begin
        case (wr_src)
            md_pkg::SRC_PRODUCT: wdata = product;
            md_pkg::SRC_DIVIDER: wdata = div_result;
            default:             wdata = {req.rs_val, req.rs_val};    // mthi/mtlo
        endcase
    end

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            hilo_q <= '0;
        end else begin
            if (hi_wen) hilo_q.hi <= wdata.hi;
            if (lo_wen) hilo_q.lo <= wdata.lo;
        end
    end

    always_comb begin
        case (req.op)
            md_pkg::OP_MFHI: rdata = hilo_q.hi;
            md_pkg::OP_MFLO: rdata = hilo_q.lo;
            default:         rdata = '0;
        endcase
    end

endmodule

// ==== design/md_ctrl.sv ====
`timescale 1ns/1ps

module md_ctrl #(
    parameter int WIDTH = md_pkg::DATA_W
) (
    input  logic              aclk,
    input  logic              aresetn,
    input  logic              req_valid,
    input  md_pkg::md_req_t   req,
    input  logic              last_step,
    output logic              stall,
    output logic              busy,
    output logic              cnt_start,
    output logic              div_load,
    output logic              div_step,
    output logic              div_signed,
    output logic              hi_wen,
    output logic              lo_wen,
    output logic [1:0]        wr_src
);

    md_pkg::div_state_e state;
    md_pkg::div_state_e state_nxt;
    logic               div_req;    // div/divu, never held off
    logic               hilo_req;
    logic               accept;

    assign div_req  = req_valid && (req.op == md_pkg::OP_DIV || req.op == md_pkg::OP_DIVU);
    assign hilo_req = req_valid && (req.op inside {md_pkg::OP_MULT, md_pkg::OP_MULTU,
                                                   md_pkg::OP_MTHI, md_pkg::OP_MTLO,
                                                   md_pkg::OP_MFHI, md_pkg::OP_MFLO});

    assign busy   = state != md_pkg::S_IDLE;
    assign stall  = hilo_req && busy;
    assign accept = req_valid && !stall;

    // a div while busy reloads and restarts the count
    assign cnt_start  = div_req;
    assign div_load   = div_req;
    assign div_step   = state == md_pkg::S_BUSY;
    assign div_signed = req.op == md_pkg::OP_DIV;

    always_comb begin
        state_nxt = state;
        case (state)
            md_pkg::S_IDLE: begin
                if (div_req) state_nxt = md_pkg::S_BUSY;
            end
            md_pkg::S_BUSY: begin
                if (div_req)        state_nxt = md_pkg::S_BUSY;
                else if (last_step) state_nxt = md_pkg::S_FINISH;
            end
            md_pkg::S_FINISH: begin
                state_nxt = div_req ? md_pkg::S_BUSY : md_pkg::S_IDLE;
            end
            default: state_nxt = md_pkg::S_IDLE;
        endcase
    end

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            state <= md_pkg::S_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        hi_wen = 1'b0;
        lo_wen = 1'b0;
        wr_src = md_pkg::SRC_DIVIDER;
        if (state == md_pkg::S_FINISH && !div_req) begin
            hi_wen = 1'b1;    // remainder and quotient together
            lo_wen = 1'b1;
        end else if (accept) begin
            case (req.op)
                md_pkg::OP_MULT, md_pkg::OP_MULTU: begin
                    hi_wen = 1'b1;
                    lo_wen = 1'b1;
                    wr_src = md_pkg::SRC_PRODUCT;
                end
                md_pkg::OP_MTHI: begin
                    hi_wen = 1'b1;
                    wr_src = md_pkg::SRC_OPERAND;
                end
                md_pkg::OP_MTLO: begin
                    lo_wen = 1'b1;
                    wr_src = md_pkg::SRC_OPERAND;
                end
                default: ;
            endcase
        end
    end

    // a product write must never land on top of a running division
    a_no_mult_while_busy: assert property (@(posedge aclk) disable iff (!aresetn)
        hi_wen && wr_src == md_pkg::SRC_PRODUCT |-> !busy);

    a_stall_needs_busy: assert property (@(posedge aclk) disable iff (!aresetn)
        stall |-> busy);

    // cancels only lengthen busy
    a_div_busy_len: assert property (@(posedge aclk) disable iff (!aresetn)
        div_req |=> busy [*WIDTH]);

endmodule

// ==== design/md_pkg.sv ====
package md_pkg;

    parameter int DATA_W = 32;

    // low four bits of the SPECIAL funct codes 0x10..0x1b
    // a fourth bit is needed since none makes nine codes
    typedef enum logic [3:0] {
        OP_MFHI  = 4'b0000,
        OP_MTHI  = 4'b0001,
        OP_MFLO  = 4'b0010,
        OP_MTLO  = 4'b0011,
        OP_MULT  = 4'b1000,
        OP_MULTU = 4'b1001,
        OP_DIV   = 4'b1010,
        OP_DIVU  = 4'b1011,
        OP_NONE  = 4'b1111
    } md_op_e;

    typedef struct packed {
        md_op_e              op;
        logic [DATA_W-1:0]   rs_val;
        logic [DATA_W-1:0]   rt_val;
    } md_req_t;

    typedef struct packed {
        logic [DATA_W-1:0]   hi;
        logic [DATA_W-1:0]   lo;
    } hilo_t;

    typedef enum logic [1:0] {
        S_IDLE   = 2'd0,
        S_BUSY   = 2'd1,
        S_FINISH = 2'd2
    } div_state_e;

    // HI/LO write source select
    localparam logic [1:0] SRC_PRODUCT = 2'd0;
    localparam logic [1:0] SRC_DIVIDER = 2'd1;
    localparam logic [1:0] SRC_OPERAND = 2'd2;

endpackage

// ==== design/muldiv_top.sv ====
`timescale 1ns/1ps

module muldiv_top #(
    parameter int WIDTH = md_pkg::DATA_W
) (
    input  logic               aclk,
    input  logic               aresetn,
    input  logic               req_valid,
    input  md_pkg::md_req_t    req,
    output logic               stall,
    output logic               busy,
    output logic [WIDTH-1:0]   rdata
);

    logic          cnt_start;
    logic          last_step;
    logic          div_load;
    logic          div_step;
    logic          div_signed;
    logic          hi_wen;
    logic          lo_wen;
    logic [1:0]    wr_src;
    md_pkg::hilo_t div_result;    // remainder on hi, quotient on lo

    md_ctrl #(
        .WIDTH      (WIDTH)
    ) u_ctrl (
        .aclk       (aclk),
        .aresetn    (aresetn),
        .req_valid  (req_valid),
        .req        (req),
        .last_step  (last_step),
        .stall      (stall),
        .busy       (busy),
        .cnt_start  (cnt_start),
        .div_load   (div_load),
        .div_step   (div_step),
        .div_signed (div_signed),
        .hi_wen     (hi_wen),
        .lo_wen     (lo_wen),
        .wr_src     (wr_src)
    );

    div_step_counter #(
        .WIDTH      (WIDTH)
    ) u_cnt (
        .aclk       (aclk),
        .aresetn    (aresetn),
        .start      (cnt_start),
        .enable     (div_step),
        .last_step  (last_step)
    );

    div_datapath #(
        .WIDTH      (WIDTH)
    ) u_div (
        .aclk       (aclk),
        .aresetn    (aresetn),
        .load       (div_load),
        .step       (div_step),
        .is_signed  (div_signed),
        .dividend   (req.rs_val),
        .divisor    (req.rt_val),
        .result     (div_result)
    );

    hilo_file #(
        .WIDTH      (WIDTH)
    ) u_hilo (
        .aclk       (aclk),
        .aresetn    (aresetn),
        .req        (req),
        .hi_wen     (hi_wen),
        .lo_wen     (lo_wen),
        .wr_src     (wr_src),
        .div_result (div_result),
        .rdata      (rdata)
    );

endmodule

// ==== dv/muldiv_tb.sv ====
`timescale 1ns/1ps

module muldiv_tb;

    localparam int WIDTH   = md_pkg::DATA_W;
    localparam int VEC_MAX = 64;
    localparam int N_DIV   = 16;    // random divides
    localparam int N_MOVE  = 8;     // random mthi/mtlo values

    logic              aclk;
    logic              aresetn;
    logic              req_valid;
    md_pkg::md_req_t   req;
    logic              stall;
    logic              busy;
    logic [WIDTH-1:0]  rdata;

    logic [31:0]       vec_mem [0:5*VEC_MAX];    // count word, then 5 words per vector
    logic [31:0]       rng_state;
    logic [WIDTH-1:0]  model_hi;
    logic [WIDTH-1:0]  model_lo;
    int                n_vec;
    int                cycle_cnt = 0;
    int                cycle_limit;

    tb_clock_gen #(
        .PERIOD_NS    (40),
        .RESET_CYCLES (4)
    ) u_clk (
        .aclk    (aclk),
        .aresetn (aresetn)
    );

    muldiv_top #(
        .WIDTH     (WIDTH)
    ) dut (
        .aclk      (aclk),
        .aresetn   (aresetn),
        .req_valid (req_valid),
        .req       (req),
        .stall     (stall),
        .busy      (busy),
        .rdata     (rdata)
    );

    always @(posedge aclk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= cycle_limit) begin
            $display("run timed out after %0d cycles", cycle_cnt);
            $display("Test failed");
            $fatal(1, "timeout");
        end
    end

    function automatic logic [31:0] lcg_next();
        rng_state = rng_state * 32'd1103515245 + 32'd12345;
        return rng_state ^ (rng_state >> 15);    // fold high bits into the weak low ones
    endfunction

    // remainder on the high word, quotient on the low word
    function automatic logic [63:0] div_expect(input logic is_signed, input logic [31:0] a,
                                               input logic [31:0] b);
        int sa;
        int sb;
        sa = a;
        sb = b;
        if (is_signed) return {32'(sa % sb), 32'(sa / sb)};
        return {a % b, a / b};
    endfunction

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] want);
        if (got !== want) begin
            $display("ERR %0t %s got %h expected %h", $time, name, got, want);
            $display("Test failed");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    // holds the request while stalled; rd is sampled in the accepting cycle
    task automatic request(input md_pkg::md_op_e op, input logic [31:0] rs,
                           input logic [31:0] rt, output logic [WIDTH-1:0] rd,
                           output int stalls);
        req_valid  = 1'b1;
        req.op     = op;
        req.rs_val = rs;
        req.rt_val = rt;
        stalls     = 0;
        @(negedge aclk);
        while (stall) begin
            check_value("busy while stalled", busy, 1);
            stalls++;
            @(negedge aclk);
        end
        rd = rdata;
        @(posedge aclk);
        #2;
        req_valid = 1'b0;
        req.op    = md_pkg::OP_NONE;
    endtask

    task automatic send(input md_pkg::md_op_e op, input logic [31:0] rs, input logic [31:0] rt);
        logic [WIDTH-1:0] rd;
        int               stalls;
        request(op, rs, rt, rd, stalls);
    endtask

    task automatic check_hilo(input logic [WIDTH-1:0] exp_hi, input logic [WIDTH-1:0] exp_lo);
        logic [WIDTH-1:0] rd;
        int               stalls;
        request(md_pkg::OP_MFHI, '0, '0, rd, stalls);
        check_value("rdata (mfhi)", rd, exp_hi);
        request(md_pkg::OP_MFLO, '0, '0, rd, stalls);
        check_value("rdata (mflo)", rd, exp_lo);
        model_hi = exp_hi;
        model_lo = exp_lo;
    endtask

    task automatic wait_div_done(output int cycles);
        cycles = 0;
        @(negedge aclk);
        while (busy) begin
            cycles++;
            @(negedge aclk);
        end
        @(posedge aclk);
        #2;
    endtask

    task automatic run_multiply(input md_pkg::md_op_e op, input logic [31:0] rs,
                                input logic [31:0] rt, input logic [63:0] want);
        send(op, rs, rt);
        check_hilo(want[63:32], want[31:0]);
    endtask

    task automatic run_divide(input md_pkg::md_op_e op, input logic [31:0] rs,
                              input logic [31:0] rt, input logic [63:0] want);
        int cycles;
        send(op, rs, rt);
        wait_div_done(cycles);
        check_value("busy cycles", cycles, WIDTH);
        check_hilo(want[63:32], want[31:0]);
    endtask

    initial begin
        logic [WIDTH-1:0] rd;
        logic [31:0]      rs;
        logic [31:0]      rt;
        logic [31:0]      v;
        logic [63:0]      want;
        logic             is_signed;
        md_pkg::md_op_e   op;
        int               stalls;
        int               cycles;

        req_valid = 1'b0;
        req       = '{op: md_pkg::OP_NONE, rs_val: '0, rt_val: '0};
        rng_state = 32'd48782;
        model_hi  = '0;
        model_lo  = '0;
        vec_mem[0] = '0;
        $readmemh("dv/muldiv_vectors.txt", vec_mem);
        n_vec = vec_mem[0];
        if (n_vec <= 0 || n_vec > VEC_MAX) begin
            $display("vector file is missing or its count word is out of range");
            $display("Test failed");
            $fatal(1, "bad vector file");
        end
        cycle_limit = (n_vec + N_DIV + N_MOVE) * (WIDTH + 6) + 100;

        // reset state
        wait (aresetn === 1'b1);
        @(negedge aclk);
        check_value("busy", busy, 0);
        check_value("stall", stall, 0);
        @(posedge aclk);
        #2;
        check_hilo('0, '0);

        for (int i = 0; i < n_vec; i++) begin
            op   = md_pkg::md_op_e'(vec_mem[1 + 5*i][3:0]);
            rs   = vec_mem[2 + 5*i];
            rt   = vec_mem[3 + 5*i];
            want = {vec_mem[4 + 5*i], vec_mem[5 + 5*i]};
            case (op)
                md_pkg::OP_MULT, md_pkg::OP_MULTU: run_multiply(op, rs, rt, want);
                md_pkg::OP_DIV, md_pkg::OP_DIVU:   run_divide(op, rs, rt, want);
                default: begin
                    $display("vector %0d holds an op that is not a multiply or divide", i);
                    $display("Test failed");
                    $fatal(1, "bad vector op");
                end
            endcase
        end

        for (int i = 0; i < N_DIV; i++) begin
            is_signed = i[0] == 1'b0;
            rs = lcg_next();
            v  = lcg_next();
            rt = lcg_next() >> v[4:0];    // spread of divisor sizes
            if (is_signed && v[5]) rt = -rt;
            if (rt == '0) rt = 32'd3;
            if (is_signed && rs == 32'h8000_0000 && rt == '1) rt = 32'd5;    // quotient overflow
            op = is_signed ? md_pkg::OP_DIV : md_pkg::OP_DIVU;
            run_divide(op, rs, rt, div_expect(is_signed, rs, rt));
        end

        // moves, the other register must keep its value
        for (int i = 0; i < N_MOVE; i++) begin
            v = lcg_next();
            if (i[0] == 1'b0) begin
                send(md_pkg::OP_MTHI, v, '0);
                check_hilo(v, model_lo);
            end else begin
                send(md_pkg::OP_MTLO, v, '0);
                check_hilo(model_hi, v);
            end
        end

        // mflo right behind a divide
        rs   = lcg_next();
        rt   = (lcg_next() >> 8) | 32'd1;
        want = div_expect(1'b0, rs, rt);
        send(md_pkg::OP_DIVU, rs, rt);
        request(md_pkg::OP_MFLO, '0, '0, rd, stalls);
        check_value("stall cycles", stalls, WIDTH);
        check_value("rdata (mflo after stall)", rd, want[31:0]);
        check_hilo(want[63:32], want[31:0]);

        // second div three cycles into the first
        send(md_pkg::OP_DIV, 32'd100, 32'd7);
        repeat (3) begin
            @(posedge aclk);
            #2;
        end
        rs   = 32'hffff_fc18;    // -1000
        rt   = 32'd9;
        want = div_expect(1'b1, rs, rt);
        send(md_pkg::OP_DIV, rs, rt);
        wait_div_done(cycles);
        check_value("busy cycles after cancel", cycles, WIDTH);
        check_hilo(want[63:32], want[31:0]);

        $display("Test completed successfully");
        $finish;
    end

endmodule

// ==== dv/muldiv_vectors.txt ====
// first word: number of vectors, hex
// then one per line: op rs_val rt_val expected_hi expected_lo (op 8 mult, 9 multu, a div, b divu)
16
8 00000007 00000006 00000000 0000002a
8 fffffffd 00000005 ffffffff fffffff1
8 ffffffff ffffffff 00000000 00000001
8 80000000 80000000 40000000 00000000
8 7fffffff 7fffffff 3fffffff 00000001
8 80000000 7fffffff c0000000 80000000
8 12345678 ffffffff ffffffff edcba988
9 ffffffff ffffffff fffffffe 00000001
9 80000000 00000002 00000001 00000000
9 12345678 ffffffff 12345677 edcba988
9 fffffffd 00000005 00000004 fffffff1
a 00000064 00000007 00000002 0000000e
a ffffff9c 00000007 fffffffe fffffff2
a 00000064 fffffff9 00000002 fffffff2
a ffffff9c fffffff9 fffffffe 0000000e
a 80000000 00000002 00000000 c0000000
a 7fffffff 80000000 7fffffff 00000000
a 00000005 0000000a 00000005 00000000
b ffffffff 00000010 0000000f 0fffffff
b 80000000 00000003 00000002 2aaaaaaa
b ffffff9c 00000007 00000002 24924916
b 12345678 12345678 00000000 00000001

// ==== dv/tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int PERIOD_NS    = 40,
    parameter int RESET_CYCLES = 4
) (
    output logic aclk,
    output logic aresetn
);

    initial begin
        aclk = 1'b0;
        forever #(PERIOD_NS / 2) aclk = ~aclk;
    end

    // released 2 ns after the last reset edge, like the other inputs
    initial begin
        aresetn = 1'b0;
        repeat (RESET_CYCLES) @(posedge aclk);
        #2 aresetn = 1'b1;
    end

endmodule

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module muldiv_tb -f src.f -o sim_muldiv

# the log decides the result, so a failing run must not stop the script here
./obj_dir/sim_muldiv > sim.log 2>&1 || true
cat sim.log

if grep -q "Test failed" sim.log; then
    echo "simulation reported failure"
    exit 1
fi
if ! grep -q "Test completed successfully" sim.log; then
    echo "simulation ended without a result"
    exit 1
fi
echo "simulation passed"

// ==== src.f ====
design/md_pkg.sv
design/md_ctrl.sv
design/div_step_counter.sv
design/div_datapath.sv
design/hilo_file.sv
design/muldiv_top.sv
dv/tb_clock_gen.sv
dv/muldiv_tb.sv
